// File: logic/icache_pkg.sv
package icache_pkg;

  // Address and fetch widths
  localparam int VADDR_W       = 32;
  localparam int PTAG_W        = 20;
  localparam int PAGE_OFFSET_W = 12;
  localparam int PADDR_W       = PTAG_W + PAGE_OFFSET_W;
  localparam int INSTR_W       = 32;

  // Cache geometry
  localparam int BLOCK_W        = 128;
  localparam int SETS_DEFAULT   = 64;
  localparam int ASSOC_DEFAULT  = 2;
  localparam int BLOCK_OFFSET_W = 4;
  localparam int INDEX_W        = $clog2(SETS_DEFAULT);

  // Instruction select within a block
  localparam int INSTR_PER_BLOCK = BLOCK_W / INSTR_W;
  localparam int WORD_SEL_W      = $clog2(INSTR_PER_BLOCK);
  localparam int BYTE_OFFSET_W   = $clog2(INSTR_W / 8);

  // Replay queue depth, power of two
  localparam int REPLAY_ELS_DEFAULT = 8;

  // LRU state, one way number per set
  localparam int LRU_WAY_W = (ASSOC_DEFAULT > 1) ? $clog2(ASSOC_DEFAULT) : 1;
  localparam logic [LRU_WAY_W-1:0] LRU_RESET_WAY = '0;

  // Fetch request as it sits in the replay queue
  typedef struct packed {
    logic [VADDR_W-1:0] vaddr;
    logic [PTAG_W-1:0]  ptag;
  } req_t;

endpackage

// File: logic/icache_replay_fifo.sv
module icache_replay_fifo #(
  parameter int els_p = icache_pkg::REPLAY_ELS_DEFAULT
) (
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  icache_pkg::req_t req_i,
  input  logic             req_v_i,
  output logic             ready_o,

  output icache_pkg::req_t req_o,
  output logic             req_v_o,
  input  logic             yumi_i,

  input  logic             commit_i,
  input  logic             roll_i
);

  import icache_pkg::*;

  localparam int addr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  // Extra bit tells full from empty
  localparam int ptr_w_lp  = addr_w_lp + 1;

  req_t                mem_r [els_p];
  logic [ptr_w_lp-1:0] wptr_r;
  logic [ptr_w_lp-1:0] rptr_r;
  logic [ptr_w_lp-1:0] cptr_r;
  logic [ptr_w_lp-1:0] used;
  logic                enq;

  // Entries stay allocated until committed
  assign used    = wptr_r - cptr_r;
  assign ready_o = (used != ptr_w_lp'(els_p));
  assign enq     = req_v_i & ready_o;

  assign req_v_o = (rptr_r != wptr_r);
  assign req_o   = mem_r[rptr_r[addr_w_lp-1:0]];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      cptr_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= wptr_r + 1'b1;
      end

      // Rollback replays everything dequeued but not yet committed
      if (roll_i) begin
        rptr_r <= cptr_r;
      end else if (yumi_i) begin
        rptr_r <= rptr_r + 1'b1;
      end

      if (commit_i) begin
        cptr_r <= cptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r[addr_w_lp-1:0]] <= req_i;
    end
  end

endmodule

// File: logic/icache_lookup.sv
module icache_lookup #(
  parameter int  sets_p   = icache_pkg::SETS_DEFAULT,
  parameter int  assoc_p  = icache_pkg::ASSOC_DEFAULT,
  localparam int way_w_lp = (assoc_p > 1) ? $clog2(assoc_p) : 1
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  input  icache_pkg::req_t               req_i,
  input  logic                           req_v_i,
  output logic                           ready_o,

  output logic [icache_pkg::INSTR_W-1:0] data_o,
  output logic                           data_v_o,

  output logic                           commit_o,
  output logic                           roll_o,

  output logic                           miss_v_o,
  output logic [icache_pkg::PADDR_W-1:0] miss_addr_o,
  input  logic                           busy_i,

  input  logic                           fill_v_i,
  input  logic [icache_pkg::INDEX_W-1:0] fill_index_i,
  input  logic [way_w_lp-1:0]            fill_way_i,
  input  logic [icache_pkg::PTAG_W-1:0]  fill_tag_i,
  input  logic [icache_pkg::BLOCK_W-1:0] fill_data_i,
  output logic [way_w_lp-1:0]            lru_way_o
);

  import icache_pkg::*;

  logic [PTAG_W-1:0]               tag_mem  [sets_p][assoc_p];
  logic [BLOCK_W-1:0]              data_mem [sets_p][assoc_p];
  logic [sets_p-1:0][assoc_p-1:0]  valid_r;
  logic [sets_p-1:0][way_w_lp-1:0] lru_r;

  logic                  accept;

  // Tag lookup
  logic                  tl_v_r;
  req_t                  tl_req_r;
  logic [INDEX_W-1:0]    tl_index;
  logic [WORD_SEL_W-1:0] tl_word;
  logic                  tl_hit;
  logic [way_w_lp-1:0]   tl_way;
  logic [BLOCK_W-1:0]    tl_block;

  // Tag verify
  logic                  tv_v_r;
  logic                  tv_poison_r;
  logic                  tv_hit_r;
  req_t                  tv_req_r;
  logic [way_w_lp-1:0]   tv_way_r;
  logic [INSTR_W-1:0]    tv_data_r;
  logic [INDEX_W-1:0]    tv_index;

  // No new request while a miss is outstanding or the queue rolls back
  assign ready_o = ~busy_i & ~roll_o;
  assign accept  = req_v_i & ready_o;

  assign tl_index = tl_req_r.vaddr[BLOCK_OFFSET_W +: INDEX_W];
  assign tl_word  = tl_req_r.vaddr[BYTE_OFFSET_W +: WORD_SEL_W];

  always_comb begin
    tl_hit   = 1'b0;
    tl_way   = '0;
    tl_block = data_mem[tl_index][0];
    for (int w = 0; w < assoc_p; w++) begin
      if (valid_r[tl_index][w] && (tag_mem[tl_index][w] == tl_req_r.ptag)) begin
        tl_hit   = 1'b1;
        tl_way   = way_w_lp'(w);
        tl_block = data_mem[tl_index][w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tl_v_r      <= 1'b0;
      tv_v_r      <= 1'b0;
      tv_poison_r <= 1'b0;
      tv_hit_r    <= 1'b0;
    end else begin
      tl_v_r      <= accept;
      tv_v_r      <= tl_v_r;
      // Younger request dies when the older one yields nothing
      tv_poison_r <= tl_v_r & roll_o;
      tv_hit_r    <= tl_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tl_req_r <= req_i;
    end
    if (tl_v_r) begin
      tv_req_r  <= tl_req_r;
      tv_way_r  <= tl_way;
      tv_data_r <= tl_block[tl_word*INSTR_W +: INSTR_W];
    end
  end

  assign tv_index = tv_req_r.vaddr[BLOCK_OFFSET_W +: INDEX_W];

  assign data_v_o    = tv_v_r & ~tv_poison_r & tv_hit_r;
  assign data_o      = tv_data_r;
  assign commit_o    = data_v_o;
  assign roll_o      = tv_v_r & ~data_v_o;
  assign miss_v_o    = tv_v_r & ~tv_poison_r & ~tv_hit_r;
  assign miss_addr_o = {tv_req_r.ptag,
                        tv_req_r.vaddr[PAGE_OFFSET_W-1:BLOCK_OFFSET_W],
                        {BLOCK_OFFSET_W{1'b0}}};

  // Victim is the lowest empty way, else the LRU way
  always_comb begin
    lru_way_o = lru_r[tv_index];
    for (int w = assoc_p - 1; w >= 0; w--) begin
      if (!valid_r[tv_index][w]) begin
        lru_way_o = way_w_lp'(w);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_r <= '0;
      for (int s = 0; s < sets_p; s++) begin
        lru_r[s] <= way_w_lp'(LRU_RESET_WAY);
      end
    end else begin
      if (fill_v_i) begin
        valid_r[fill_index_i][fill_way_i] <= 1'b1;
      end
      // Two ways, so LRU is simply the other way
      if (data_v_o) begin
        lru_r[tv_index] <= ~tv_way_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_mem[fill_index_i][fill_way_i]  <= fill_tag_i;
      data_mem[fill_index_i][fill_way_i] <= fill_data_i;
    end
  end

endmodule

// File: logic/icache_uce.sv
module icache_uce #(
  parameter int  assoc_p  = icache_pkg::ASSOC_DEFAULT,
  localparam int way_w_lp = (assoc_p > 1) ? $clog2(assoc_p) : 1
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  input  logic                           miss_v_i,
  input  logic [icache_pkg::PADDR_W-1:0] miss_addr_i,
  input  logic [way_w_lp-1:0]            lru_way_i,
  output logic                           busy_o,

  output logic [icache_pkg::PADDR_W-1:0] mem_cmd_addr_o,
  output logic                           mem_cmd_v_o,
  input  logic                           mem_cmd_ready_i,

  input  logic [icache_pkg::BLOCK_W-1:0] mem_resp_data_i,
  input  logic                           mem_resp_v_i,
  output logic                           mem_resp_yumi_o,

  output logic                           fill_v_o,
  output logic [icache_pkg::INDEX_W-1:0] fill_index_o,
  output logic [way_w_lp-1:0]            fill_way_o,
  output logic [icache_pkg::PTAG_W-1:0]  fill_tag_o,
  output logic [icache_pkg::BLOCK_W-1:0] fill_data_o
);

  import icache_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_WAIT,
    S_FILL
  } state_e;

  state_e              state_r;
  state_e              state_n;
  logic [PADDR_W-1:0]  addr_r;
  logic [way_w_lp-1:0] way_r;
  logic                resp_v_r;
  logic [BLOCK_W-1:0]  resp_data_r;
  logic                fill_done_r;
  logic                latch_miss;

  assign latch_miss = miss_v_i & (state_r == S_IDLE);

  always_comb begin
    state_n = state_r;
    case (state_r)
      S_IDLE: if (miss_v_i) state_n = S_SEND;
      S_SEND: if (mem_cmd_ready_i) state_n = S_WAIT;
      S_WAIT: if (mem_resp_yumi_o) state_n = S_FILL;
      S_FILL: state_n = S_IDLE;
      default: state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r     <= S_IDLE;
      resp_v_r    <= 1'b0;
      fill_done_r <= 1'b0;
    end else begin
      state_r     <= state_n;
      fill_done_r <= (state_r == S_FILL);
      // Buffer entry frees once the block is in the arrays
      if (mem_resp_yumi_o) begin
        resp_v_r <= 1'b1;
      end else if (fill_done_r) begin
        resp_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_miss) begin
      addr_r <= {miss_addr_i[PADDR_W-1:BLOCK_OFFSET_W], {BLOCK_OFFSET_W{1'b0}}};
      way_r  <= lru_way_i;
    end
    if (mem_resp_yumi_o) begin
      resp_data_r <= mem_resp_data_i;
    end
  end

  assign busy_o = (state_r != S_IDLE);

  assign mem_cmd_v_o     = (state_r == S_SEND);
  assign mem_cmd_addr_o  = addr_r;
  assign mem_resp_yumi_o = mem_resp_v_i & ~resp_v_r & (state_r == S_WAIT);

  assign fill_v_o     = (state_r == S_FILL);
  assign fill_index_o = addr_r[BLOCK_OFFSET_W +: INDEX_W];
  assign fill_tag_o   = addr_r[PADDR_W-1 -: PTAG_W];
  assign fill_way_o   = way_r;
  assign fill_data_o  = resp_data_r;

endmodule

// File: logic/icache_top.sv
module icache_top #(
  parameter int  sets_p   = icache_pkg::SETS_DEFAULT,
  parameter int  assoc_p  = icache_pkg::ASSOC_DEFAULT,
  parameter int  els_p    = icache_pkg::REPLAY_ELS_DEFAULT,
  localparam int way_w_lp = (assoc_p > 1) ? $clog2(assoc_p) : 1
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  input  logic [icache_pkg::VADDR_W-1:0] vaddr_i,
  input  logic [icache_pkg::PTAG_W-1:0]  ptag_i,
  input  logic                           vaddr_v_i,
  output logic                           vaddr_ready_o,

  output logic [icache_pkg::INSTR_W-1:0] data_o,
  output logic                           data_v_o,

  output logic [icache_pkg::PADDR_W-1:0] mem_cmd_addr_o,
  output logic                           mem_cmd_v_o,
  input  logic                           mem_cmd_ready_i,

  input  logic [icache_pkg::BLOCK_W-1:0] mem_resp_data_i,
  input  logic                           mem_resp_v_i,
  output logic                           mem_resp_yumi_o
);

  import icache_pkg::*;

  req_t               enq_req;
  req_t               q_req;
  logic               q_req_v;
  logic               q_yumi;
  logic               lk_ready;
  logic               commit;
  logic               roll;
  logic               miss_v;
  logic [PADDR_W-1:0] miss_addr;
  logic [way_w_lp-1:0] lru_way;
  logic               busy;
  logic               fill_v;
  logic [INDEX_W-1:0] fill_index;
  logic [way_w_lp-1:0] fill_way;
  logic [PTAG_W-1:0]  fill_tag;
  logic [BLOCK_W-1:0] fill_data;

  assign enq_req = '{vaddr: vaddr_i, ptag: ptag_i};
  assign q_yumi  = q_req_v & lk_ready;

  icache_replay_fifo #(
    .els_p(els_p)
  ) replay_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (enq_req),
    .req_v_i  (vaddr_v_i),
    .ready_o  (vaddr_ready_o),
    .req_o    (q_req),
    .req_v_o  (q_req_v),
    .yumi_i   (q_yumi),
    .commit_i (commit),
    .roll_i   (roll)
  );

  icache_lookup #(
    .sets_p  (sets_p),
    .assoc_p (assoc_p)
  ) lookup_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (q_req),
    .req_v_i      (q_req_v),
    .ready_o      (lk_ready),
    .data_o       (data_o),
    .data_v_o     (data_v_o),
    .commit_o     (commit),
    .roll_o       (roll),
    .miss_v_o     (miss_v),
    .miss_addr_o  (miss_addr),
    .busy_i       (busy),
    .fill_v_i     (fill_v),
    .fill_index_i (fill_index),
    .fill_way_i   (fill_way),
    .fill_tag_i   (fill_tag),
    .fill_data_i  (fill_data),
    .lru_way_o    (lru_way)
  );

  icache_uce #(
    .assoc_p(assoc_p)
  ) uce_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .miss_v_i        (miss_v),
    .miss_addr_i     (miss_addr),
    .lru_way_i       (lru_way),
    .busy_o          (busy),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_resp_data_i (mem_resp_data_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_yumi_o (mem_resp_yumi_o),
    .fill_v_o        (fill_v),
    .fill_index_o    (fill_index),
    .fill_way_o      (fill_way),
    .fill_tag_o      (fill_tag),
    .fill_data_o     (fill_data)
  );

endmodule

// File: dv/icache_mem_model.sv
module icache_mem_model #(
  parameter int seed_p = 32'h8ee6
) (
  input  logic         clk_i,
  input  logic         arst_n_i,

  input  logic [31:0]  mem_cmd_addr_i,
  input  logic         mem_cmd_v_i,
  output logic         mem_cmd_ready_o,

  output logic [127:0] mem_resp_data_o,
  output logic         mem_resp_v_o,
  input  logic         mem_resp_yumi_i
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] word_xor_lp  = 32'h5a5a_0000;
  localparam int          max_delay_lp = 7;

  integer seed;
  logic   busy_r;
  int     delay_r;

  // Word at address a is (a >> 2) ^ 5a5a_0000, lowest word in the low bits
  function automatic logic [127:0] block_data(input logic [31:0] addr);
    logic [127:0] blk;
    logic [31:0]  word_addr;
    word_addr = addr >> 2;
    for (int i = 0; i < 4; i++) begin
      blk[i*32 +: 32] = (word_addr + 32'(i)) ^ word_xor_lp;
    end
    return blk;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seed = seed_p;
      mem_cmd_ready_o <= 1'b0;
      mem_resp_v_o    <= 1'b0;
      mem_resp_data_o <= '0;
      busy_r          <= 1'b0;
      delay_r         <= 0;
    end else begin
      if (!busy_r) begin
        if (mem_cmd_v_i && mem_cmd_ready_o) begin
          busy_r          <= 1'b1;
          mem_cmd_ready_o <= 1'b0;
          delay_r         <= $random(seed) & max_delay_lp;
          mem_resp_data_o <= block_data(mem_cmd_addr_i);
        end else begin
          mem_cmd_ready_o <= ($random(seed) & 1) != 0;
        end
      end else if (!mem_resp_v_o) begin
        if (delay_r == 0) begin
          mem_resp_v_o <= 1'b1;
        end else begin
          delay_r <= delay_r - 1;
        end
      end else if (mem_resp_yumi_i) begin
        mem_resp_v_o <= 1'b0;
        busy_r       <= 1'b0;
      end
    end
  end

endmodule

// File: dv/icache_tb.sv
module icache_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import icache_pkg::*;

  localparam int num_tests_lp = 23;
  // Leading entries go in back to back, behind the first cold miss
  localparam int burst_len_lp = 12;
  localparam int timeout_lp   = num_tests_lp * 30 + 100;
  // One cycle to become visible in the queue, two through the lookup
  localparam int hit_latency_lp = 3;

  logic                 clk_i;
  logic                 arst_n_i;
  logic [VADDR_W-1:0]   vaddr_i;
  logic [PTAG_W-1:0]    ptag_i;
  logic                 vaddr_v_i;
  logic                 vaddr_ready_o;
  logic [INSTR_W-1:0]   data_o;
  logic                 data_v_o;
  logic [PADDR_W-1:0]   mem_cmd_addr_o;
  logic                 mem_cmd_v_o;
  logic                 mem_cmd_ready_i;
  logic [BLOCK_W-1:0]   mem_resp_data_i;
  logic                 mem_resp_v_i;
  logic                 mem_resp_yumi_o;

  logic [31:0] testdata [0:4*num_tests_lp-1];
  logic [31:0] miss_addrs[$];
  integer      seed;
  int          cycle_cnt;
  int          last_accept;
  int          out_idx;
  int          cmd_cnt;
  logic        saw_full;

  icache_top dut_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .vaddr_i         (vaddr_i),
    .ptag_i          (ptag_i),
    .vaddr_v_i       (vaddr_v_i),
    .vaddr_ready_o   (vaddr_ready_o),
    .data_o          (data_o),
    .data_v_o        (data_v_o),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_resp_data_i (mem_resp_data_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_yumi_o (mem_resp_yumi_o)
  );

  icache_mem_model #(
    .seed_p(32'h8ee6)
  ) mem_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .mem_cmd_addr_i  (mem_cmd_addr_o),
    .mem_cmd_v_i     (mem_cmd_v_o),
    .mem_cmd_ready_o (mem_cmd_ready_i),
    .mem_resp_data_o (mem_resp_data_i),
    .mem_resp_v_o    (mem_resp_v_i),
    .mem_resp_yumi_i (mem_resp_yumi_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > timeout_lp) begin
        report_failure("timeout: not all fetches returned within the cycle limit");
      end
      if (vaddr_v_i && vaddr_ready_o) begin
        last_accept = cycle_cnt;
      end
      if (!vaddr_ready_o) begin
        saw_full = 1'b1;
      end
      if (mem_resp_yumi_o && !mem_resp_v_i) begin
        report_failure("mem_resp_yumi_o raised without mem_resp_v_i");
      end
      if (data_v_o) begin
        if (out_idx >= num_tests_lp) begin
          report_failure("data_v_o raised after every fetch had returned");
        end
        compare_value($sformatf("instr_%0d", out_idx), testdata[4*out_idx+2], data_o);
        if (out_idx == num_tests_lp - 1) begin
          compare_value("hit_latency", 32'(hit_latency_lp), 32'(cycle_cnt - last_accept));
        end
        out_idx = out_idx + 1;
      end
      if (mem_cmd_v_o && mem_cmd_ready_i) begin
        if (cmd_cnt >= miss_addrs.size()) begin
          report_failure("more memory commands than expected misses");
        end
        compare_value("cmd_align", 32'h0, 32'(mem_cmd_addr_o[BLOCK_OFFSET_W-1:0]));
        compare_value($sformatf("cmd_addr_%0d", cmd_cnt), miss_addrs[cmd_cnt],
                      mem_cmd_addr_o);
        cmd_cnt = cmd_cnt + 1;
      end
    end
  end

  initial begin
    logic [31:0] va;
    logic [31:0] pt;
    logic [31:0] pa;
    logic        taken;

    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    vaddr_i         = '0;
    ptag_i          = '0;
    vaddr_v_i       = 1'b0;
    seed            = 32'h8ee6;
    cycle_cnt       = 0;
    last_accept     = 0;
    out_idx         = 0;
    cmd_cnt         = 0;
    saw_full        = 1'b0;
    taken           = 1'b0;

    $readmemh("dv/icache_testdata.hex", testdata);
    for (int i = 0; i < num_tests_lp; i++) begin
      va = testdata[4*i];
      pt = testdata[4*i+1];
      // Physical address, then cut down to the start of its block
      pa = {pt[PTAG_W-1:0], va[PAGE_OFFSET_W-1:0]};
      if (testdata[4*i+3][0]) begin
        miss_addrs.push_back(pa & ~32'(BLOCK_W / 8 - 1));
      end
    end

    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Idle after reset
    repeat (4) begin
      @(negedge clk_i);
      compare_value("idle_data_v", 32'h0, 32'(data_v_o));
      compare_value("idle_cmd_v", 32'h0, 32'(mem_cmd_v_o));
      compare_value("idle_resp_yumi", 32'h0, 32'(mem_resp_yumi_o));
      compare_value("idle_ready", 32'h1, 32'(vaddr_ready_o));
    end

    @(posedge clk_i);
    for (int i = 0; i < num_tests_lp; i++) begin
      if (i == num_tests_lp - 1) begin
        // Last fetch goes alone into an empty, idle cache
        vaddr_v_i <= 1'b0;
        while (out_idx < num_tests_lp - 1) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
      end else if (i >= burst_len_lp && ($random(seed) & 3) == 0) begin
        vaddr_v_i <= 1'b0;
        repeat (1 + ($random(seed) & 1)) @(posedge clk_i);
      end
      vaddr_i   <= testdata[4*i];
      ptag_i    <= testdata[4*i+1][PTAG_W-1:0];
      vaddr_v_i <= 1'b1;
      // Ready is stable mid-cycle and decides the enqueue at the next edge
      do begin
        @(negedge clk_i);
        taken = vaddr_ready_o;
        @(posedge clk_i);
      end while (!taken);
    end
    vaddr_v_i <= 1'b0;

    while (out_idx < num_tests_lp) @(posedge clk_i);
    repeat (4) @(posedge clk_i);

    compare_value("cmd_count", 32'(miss_addrs.size()), 32'(cmd_cnt));
    if (!saw_full) begin
      report_failure("vaddr_ready_o never dropped during the burst behind a miss");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: dv/icache_testdata.hex
// vaddr    ptag  instr    miss
// instr is ({ptag, vaddr[11:0]} >> 2) ^ 5a5a0000
00001000 00010 5a5a4000 1
00001004 00010 5a5a4001 0
00001008 00010 5a5a4002 0
0000100c 00010 5a5a4003 0
00001010 00010 5a5a4004 1
00001014 00010 5a5a4005 0
00001020 00010 5a5a4008 1
00001000 00010 5a5a4000 0
00002000 00022 5a5a8800 1
00003004 00033 5a5acc01 1
00001008 00010 5a5a4002 1
00002004 00022 5a5a8801 1
00001024 00010 5a5a4009 0
0000101c 00010 5a5a4007 0
00001ff0 000ab 5a58affc 1
00001ffc 000ab 5a58afff 0
0000100c 00010 5a5a4003 0
00003008 00033 5a5acc02 1
00002008 00022 5a5a8802 1
00003000 00033 5a5acc00 0
00004040 00044 5a5b1010 1
00004048 00044 5a5b1012 0
00001ff4 000ab 5a58affd 0

// File: tb.f
logic/icache_pkg.sv
logic/icache_replay_fifo.sv
logic/icache_lookup.sv
logic/icache_uce.sv
logic/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?=

.PHONY: sim clean

sim:
	$(VERILATOR) --binary -j 0 --timescale $(TIMESCALE) $(VFLAGS) \
		--top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
